/* build.f */
lc3Pkg.sv
regFile.sv
datapath.sv
controlUnit.sv
memBridge.sv
lc3Cpu.sv
tbMemory.sv
tbLc3.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tbLc3
FILELIST  = build.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tbLc3.sv */
`timescale 1ns/1ps

module tbLc3
    import lc3Pkg::*;
();

    localparam logic [15:0] codeBase   = 16'h3000;
    localparam logic [15:0] resBase    = 16'h3080;
    localparam logic [15:0] doneAddr   = 16'h30F0;
    localparam int          cycleLimit = 20000;

    logic        Clk = 1'b0;
    logic        reset;
    logic        hold;
    logic        slow;
    logic        fill;
    logic        loadEn;
    logic [15:0] loadAdr;
    logic [15:0] loadDat;
    wbReq        wb;
    wbRsp        wbIn;
    logic [15:0] pc;
    logic [15:0] ir;
    logic [11:0] led;

    logic [15:0] asmPc;
    int          errors;
    int          busErrors;
    int          checks;
    int          cycles;
    logic        lastCyc = 1'b0;
    logic        lastAck = 1'b0;
    logic [15:0] lastAdr = '0;

    always #5 Clk = ~Clk;

    lc3Cpu #(
        .startAddr (codeBase)
    ) dut0 (
        .Clk   (Clk),
        .reset (reset),
        .wb    (wb),
        .wbIn  (wbIn),
        .pc    (pc),
        .ir    (ir),
        .led   (led)
    );

    tbMemory mem0 (
        .Clk     (Clk),
        .reset   (reset),
        .hold    (hold),
        .slow    (slow),
        .fill    (fill),
        .loadEn  (loadEn),
        .loadAdr (loadAdr),
        .loadDat (loadDat),
        .wb      (wb),
        .wbIn    (wbIn)
    );

    // instruction encoders
    function automatic logic [15:0] addImm(input logic [2:0] d, input logic [2:0] s,
                                           input logic [4:0] imm);
        return {opAdd, d, s, 1'b1, imm};
    endfunction

    function automatic logic [15:0] addReg(input logic [2:0] d, input logic [2:0] s1,
                                           input logic [2:0] s2);
        return {opAdd, d, s1, 3'b000, s2};
    endfunction

    function automatic logic [15:0] andImm(input logic [2:0] d, input logic [2:0] s,
                                           input logic [4:0] imm);
        return {opAnd, d, s, 1'b1, imm};
    endfunction

    function automatic logic [15:0] andReg(input logic [2:0] d, input logic [2:0] s1,
                                           input logic [2:0] s2);
        return {opAnd, d, s1, 3'b000, s2};
    endfunction

    function automatic logic [15:0] notOf(input logic [2:0] d, input logic [2:0] s);
        return {opNot, d, s, 6'b111111};
    endfunction

    function automatic logic [15:0] brCond(input logic [2:0] nzp, input logic [15:0] off);
        return {opBr, nzp, off[8:0]};
    endfunction

    function automatic logic [15:0] jmpTo(input logic [2:0] base);
        return {opJmp, 3'b000, base, 6'b000000};
    endfunction

    function automatic logic [15:0] jsrRel(input logic [15:0] off);
        return {opJsr, 1'b1, off[10:0]};
    endfunction

    function automatic logic [15:0] ldRel(input logic [2:0] d, input logic [15:0] off);
        return {opLd, d, off[8:0]};
    endfunction

    function automatic logic [15:0] stRel(input logic [2:0] s, input logic [15:0] off);
        return {opSt, s, off[8:0]};
    endfunction

    function automatic logic [15:0] leaRel(input logic [2:0] d, input logic [15:0] off);
        return {opLea, d, off[8:0]};
    endfunction

    function automatic logic [15:0] ldrBase(input logic [2:0] d, input logic [2:0] base,
                                            input logic [5:0] off);
        return {opLdr, d, base, off};
    endfunction

    function automatic logic [15:0] strBase(input logic [2:0] s, input logic [2:0] base,
                                            input logic [5:0] off);
        return {opStr, s, base, off};
    endfunction

    function automatic logic [15:0] pauseWith(input logic [11:0] value);
        return {opPause, value};
    endfunction

    // offsets count from the incremented pc
    function automatic logic [15:0] pcOff(input logic [15:0] target);
        return target - asmPc - 16'd1;
    endfunction

    // stall the bus and refill memory before code goes to codeBase
    task automatic startProgram;
        hold = 1'b1;
        fill = 1'b1;
        @(negedge Clk);
        fill  = 1'b0;
        asmPc = codeBase;
    endtask

    task automatic emit(input logic [15:0] word);
        loadEn  = 1'b1;
        loadAdr = asmPc;
        loadDat = word;
        asmPc   = asmPc + 16'd1;
        @(negedge Clk);
    endtask

    // marker store followed by a branch to itself
    task automatic appendDone;
        emit(stRel(3'd0, pcOff(doneAddr)));
        emit(brCond(3'b111, 16'hFFFF));
    endtask

    task automatic resetAndRun(input string name);
        loadEn = 1'b0;
        reset  = 1'b1;
        repeat (2) @(negedge Clk);
        // pc starts at the code base and ir is cleared
        checks += 2;
        if (pc !== codeBase) begin
            errors++;
            $display("FAIL %s: pc after reset expected %h actual %h", name, codeBase, pc);
        end
        if (ir !== 16'h0000) begin
            errors++;
            $display("FAIL %s: ir after reset expected %h actual %h", name, 16'h0000, ir);
        end
        reset = 1'b0;
        hold  = 1'b0;
        while (!(wb.cyc && wb.we && wb.adr == doneAddr))
            @(negedge Clk);
        // the word is written once ack is raised
        while (wb.cyc)
            @(negedge Clk);
    endtask

    task automatic compareWord(input string name, input logic [15:0] adr,
                               input logic [15:0] exp);
        logic [15:0] act;
        act = mem0.mem[adr];
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAIL %s: word %h expected %h actual %h", name, adr, exp, act);
        end
    endtask

    task automatic arithmeticOps(input string name, input logic slowAck);
        logic [15:0] a;
        logic [15:0] b;
        a    = 16'd7;
        b    = 16'hFFFD;
        slow = slowAck;
        startProgram();
        emit(addImm(3'd1, 3'd0, 5'd7));
        emit(addImm(3'd2, 3'd0, 5'h1D));
        emit(addReg(3'd3, 3'd1, 3'd2));
        emit(andImm(3'd4, 3'd2, 5'h0E));
        emit(andReg(3'd5, 3'd1, 3'd2));
        emit(notOf(3'd6, 3'd1));
        emit(addImm(3'd7, 3'd2, 5'h10));
        emit(stRel(3'd3, pcOff(resBase)));
        emit(stRel(3'd4, pcOff(resBase + 16'd1)));
        emit(stRel(3'd5, pcOff(resBase + 16'd2)));
        emit(stRel(3'd6, pcOff(resBase + 16'd3)));
        emit(stRel(3'd7, pcOff(resBase + 16'd4)));
        appendDone();
        resetAndRun(name);
        compareWord(name, resBase, a + b);
        compareWord(name, resBase + 16'd1, b & 16'h000E);
        compareWord(name, resBase + 16'd2, a & b);
        compareWord(name, resBase + 16'd3, ~a);
        compareWord(name, resBase + 16'd4, b + 16'hFFF0);
        slow = 1'b0;
    endtask

    task automatic branchLoop(input string name);
        logic [15:0] loopAt;
        logic [15:0] untouched;
        startProgram();
        untouched = mem0.mem[resBase + 16'd1];
        emit(addImm(3'd1, 3'd0, 5'd5));
        loopAt = asmPc;
        emit(addImm(3'd2, 3'd2, 5'd3));
        emit(addImm(3'd1, 3'd1, 5'h1F));
        emit(brCond(3'b001, pcOff(loopAt)));
        emit(stRel(3'd2, pcOff(resBase)));
        // with cc positive brz falls through and br nzp skips the store
        emit(addImm(3'd3, 3'd0, 5'd1));
        emit(brCond(3'b010, 16'd1));
        emit(brCond(3'b111, 16'd1));
        emit(stRel(3'd3, pcOff(resBase + 16'd1)));
        appendDone();
        resetAndRun(name);
        compareWord(name, resBase, 16'd5 * 16'd3);
        compareWord(name, resBase + 16'd1, untouched);
    endtask

    task automatic loadsAndStores(input string name);
        logic [15:0] srcFwd;
        logic [15:0] srcBack;
        logic [15:0] leaBack;
        logic [15:0] fwdWord;
        logic [15:0] backWord;
        logic [15:0] ldrWord;
        logic [15:0] negWord;
        srcFwd  = 16'h3040;
        srcBack = 16'h2FE0;
        leaBack = 16'h2F80;
        startProgram();
        // source words as filled, before the core runs
        fwdWord  = mem0.mem[srcFwd];
        backWord = mem0.mem[srcBack];
        ldrWord  = mem0.mem[leaBack + 16'd5];
        negWord  = mem0.mem[resBase - 16'd7];
        emit(ldRel(3'd1, pcOff(srcFwd)));
        emit(ldRel(3'd2, pcOff(srcBack)));
        emit(leaRel(3'd3, pcOff(leaBack)));
        emit(leaRel(3'd4, pcOff(resBase)));
        emit(ldrBase(3'd5, 3'd3, 6'd5));
        emit(ldrBase(3'd6, 3'd4, 6'h39));
        emit(strBase(3'd1, 3'd4, 6'd0));
        emit(strBase(3'd2, 3'd4, 6'd1));
        emit(strBase(3'd3, 3'd4, 6'd2));
        emit(strBase(3'd5, 3'd4, 6'd3));
        emit(strBase(3'd6, 3'd4, 6'd4));
        emit(strBase(3'd4, 3'd4, 6'd5));
        emit(strBase(3'd5, 3'd4, 6'h3E));
        appendDone();
        resetAndRun(name);
        compareWord(name, resBase, fwdWord);
        compareWord(name, resBase + 16'd1, backWord);
        compareWord(name, resBase + 16'd2, leaBack);
        compareWord(name, resBase + 16'd3, ldrWord);
        compareWord(name, resBase + 16'd4, negWord);
        compareWord(name, resBase + 16'd5, resBase);
        compareWord(name, resBase - 16'd2, ldrWord);
    endtask

    task automatic subroutineLink(input string name);
        logic [15:0] jsrAt;
        logic [15:0] subAt;
        subAt = 16'h3010;
        startProgram();
        emit(addImm(3'd1, 3'd0, 5'd2));
        jsrAt = asmPc;
        emit(jsrRel(pcOff(subAt)));
        emit(addImm(3'd1, 3'd1, 5'd4));
        emit(stRel(3'd1, pcOff(resBase)));
        emit(stRel(3'd2, pcOff(resBase + 16'd1)));
        appendDone();
        // subroutine adds one and copies the link register to r2
        asmPc = subAt;
        emit(addImm(3'd1, 3'd1, 5'd1));
        emit(addImm(3'd2, 3'd7, 5'd0));
        emit(jmpTo(3'd7));
        resetAndRun(name);
        compareWord(name, resBase, 16'd2 + 16'd1 + 16'd4);
        compareWord(name, resBase + 16'd1, jsrAt + 16'd1);
    endtask

    task automatic pauseToLed(input string name);
        logic [15:0] pauseWord;
        pauseWord = pauseWith(12'hA5C);
        startProgram();
        emit(addImm(3'd1, 3'd0, 5'd9));
        emit(pauseWord);
        emit(addImm(3'd1, 3'd1, 5'd1));
        emit(stRel(3'd1, pcOff(resBase)));
        appendDone();
        resetAndRun(name);
        checks++;
        if (led !== pauseWord[11:0]) begin
            errors++;
            $display("FAIL %s: led expected %h actual %h", name, pauseWord[11:0], led);
        end
        compareWord(name, resBase, 16'd10);
    endtask

    // a wishbone cycle may only end after its ack
    always @(negedge Clk) begin
        if (!reset && lastCyc && !lastAck && !wb.cyc) begin
            busErrors++;
            $display("wishbone cycle at address %h ended without an ack", lastAdr);
        end
        lastCyc = wb.cyc;
        lastAck = wbIn.ack;
        lastAdr = wb.adr;
    end

    initial begin
        cycles = 0;
        while (cycles < cycleLimit) begin
            @(posedge Clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a program never reached its done store", cycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        reset     = 1'b1;
        hold      = 1'b1;
        slow      = 1'b0;
        fill      = 1'b0;
        loadEn    = 1'b0;
        loadAdr   = '0;
        loadDat   = '0;
        asmPc     = codeBase;
        errors    = 0;
        busErrors = 0;
        checks    = 0;
        repeat (2) @(negedge Clk);
        reset = 1'b0;
        arithmeticOps("arithmetic", 1'b0);
        branchLoop("branching");
        loadsAndStores("loadsStores");
        subroutineLink("subroutine");
        pauseToLed("pause");
        arithmeticOps("waitStates", 1'b1);
        $display("errors: %0d check failures, %0d bus failures, %0d checks",
                 errors, busErrors, checks);
        if (errors == 0 && busErrors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tbMemory.sv */
`timescale 1ns/1ps

module tbMemory
    import lc3Pkg::*;
(
    input  logic        Clk,
    input  logic        reset,
    input  logic        hold,
    input  logic        slow,
    input  logic        fill,
    input  logic        loadEn,
    input  logic [15:0] loadAdr,
    input  logic [15:0] loadDat,
    input  wbReq        wb,
    output wbRsp        wbIn
);

    logic [15:0] mem [65536];
    wbRsp        rsp = '0;
    logic        inCycle = 1'b0;
    int          waitLeft = 0;
    integer      seed = 99;
    logic [15:0] idx;

    // address byte swapped so that no two words are equal
    function automatic logic [15:0] fillWord(input logic [15:0] a);
        return {a[7:0], a[15:8]} ^ 16'hC3A5;
    endfunction

    always @(posedge Clk) begin
        if (fill) begin
            idx = '0;
            do begin
                mem[idx] = fillWord(idx);
                idx = idx + 16'd1;
            end while (idx != '0);
        end
        if (loadEn)
            mem[loadAdr] = loadDat;
        if (reset) begin
            rsp     <= '0;
            inCycle = 1'b0;
        end else if (rsp.ack) begin
            // ack lasts exactly one cycle
            rsp.ack <= 1'b0;
            inCycle = 1'b0;
        end else if (wb.cyc && wb.stb && !hold) begin
            if (!inCycle) begin
                inCycle  = 1'b1;
                waitLeft = slow ? 3 : ($random(seed) & 3);
            end
            if (waitLeft == 0) begin
                if (wb.we)
                    mem[wb.adr] = wb.dat;
                else
                    rsp.dat <= mem[wb.adr];
                rsp.ack <= 1'b1;
            end else begin
                waitLeft = waitLeft - 1;
            end
        end
    end

    assign wbIn = rsp;

endmodule

/* lc3Cpu.sv */
`timescale 1ns/1ps

module lc3Cpu
    import lc3Pkg::*;
#(
    parameter logic [15:0] startAddr = 16'h3000
) (
    input  logic        Clk,
    input  logic        reset,
    output wbReq        wb,
    input  wbRsp        wbIn,
    output logic [15:0] pc,
    output logic [15:0] ir,
    output logic [11:0] led
);

    ctrlSignals           ctrl;
    logic                 ben;
    logic                 memReq;
    logic                 memWrite;
    logic                 memDone;
    logic [wordWidth-1:0] memData;
    logic [wordWidth-1:0] mar;
    logic [wordWidth-1:0] mdr;

    controlUnit cu0 (
        .Clk      (Clk),
        .reset    (reset),
        .ir       (ir),
        .ben      (ben),
        .memDone  (memDone),
        .ctrl     (ctrl),
        .memReq   (memReq),
        .memWrite (memWrite)
    );

    datapath #(
        .startAddr (startAddr)
    ) dp0 (
        .Clk     (Clk),
        .reset   (reset),
        .ctrl    (ctrl),
        .memData (memData),
        .ir      (ir),
        .mar     (mar),
        .mdr     (mdr),
        .pc      (pc),
        .ben     (ben),
        .led     (led)
    );

    // mar/mdr accesses onto the wishbone bus
    memBridge br0 (
        .Clk      (Clk),
        .reset    (reset),
        .memReq   (memReq),
        .memWrite (memWrite),
        .adr      (mar),
        .wrData   (mdr),
        .memDone  (memDone),
        .rdData   (memData),
        .wb       (wb),
        .wbIn     (wbIn)
    );

endmodule

/* memBridge.sv */
`timescale 1ns/1ps

module memBridge
    import lc3Pkg::*;
(
    input  logic        Clk,
    input  logic        reset,
    input  logic        memReq,
    input  logic        memWrite,
    input  logic [15:0] adr,
    input  logic [15:0] wrData,
    output logic        memDone,
    output logic [15:0] rdData,
    output wbReq        wb,
    input  wbRsp        wbIn
);

    typedef enum logic {idle, busy} bridgeState;

    bridgeState           state;
    logic [wordWidth-1:0] adrQ;
    logic [wordWidth-1:0] datQ;
    logic                 weQ;

    always_ff @(posedge Clk) begin
        if (reset) begin
            state   <= idle;
            memDone <= 1'b0;
            weQ     <= 1'b0;
        end else begin
            memDone <= 1'b0;
            case (state)
                // memReq is still high in the cycle memDone pulses
                idle: if (memReq && !memDone) begin
                    state <= busy;
                    weQ   <= memWrite;
                end
                busy: if (wbIn.ack) begin
                    state   <= idle;
                    memDone <= 1'b1;
                end
                default: state <= idle;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge Clk) begin
        if (state == idle) begin
            adrQ <= adr;
            datQ <= wrData;
        end
        if (state == busy && wbIn.ack)
            rdData <= wbIn.dat;
    end

    assign wb.cyc = (state == busy);
    assign wb.stb = (state == busy);
    assign wb.we  = weQ;
    assign wb.adr = adrQ;
    assign wb.dat = datQ;

endmodule

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit
    import lc3Pkg::*;
(
    input  logic        Clk,
    input  logic        reset,
    input  logic [15:0] ir,
    input  logic        ben,
    input  logic        memDone,
    output ctrlSignals  ctrl,
    output logic        memReq,
    output logic        memWrite
);

    typedef enum logic [4:0] {
        fetch1, fetch2, fetch3, decode,
        sAlu, sBr, sJmp, sJsr, sLea, sPause,
        sLdAddr, sLdrAddr, sLdRead, sLdLoad,
        sStAddr, sStrAddr, sStData, sStWrite
    } cuState;

    cuState   state;
    cuState   nextState;
    lc3Opcode opcode;

    assign opcode = lc3Opcode'(ir[15:12]);

    always_ff @(posedge Clk) begin
        if (reset)
            state <= fetch1;
        else
            state <= nextState;
    end

    always_comb begin
        ctrl      = '0;
        memReq    = 1'b0;
        memWrite  = 1'b0;
        nextState = state;
        case (state)
            // mar <- pc, pc <- pc + 1
            fetch1: begin
                ctrl.gatePc = 1'b1;
                ctrl.ldMar  = 1'b1;
                ctrl.ldPc   = 1'b1;
                nextState   = fetch2;
            end
            fetch2: begin
                memReq      = 1'b1;
                ctrl.mioEn  = 1'b1;
                ctrl.ldMdr  = memDone;
                if (memDone)
                    nextState = fetch3;
            end
            fetch3: begin
                ctrl.gateMdr = 1'b1;
                ctrl.ldIr    = 1'b1;
                nextState    = decode;
            end
            decode: begin
                ctrl.ldBen = 1'b1;
                case (opcode)
                    opAdd, opAnd, opNot: nextState = sAlu;
                    opBr:    nextState = sBr;
                    opJmp:   nextState = sJmp;
                    opJsr:   nextState = sJsr;
                    opLea:   nextState = sLea;
                    opPause: nextState = sPause;
                    opLd:    nextState = sLdAddr;
                    opLdr:   nextState = sLdrAddr;
                    opSt:    nextState = sStAddr;
                    opStr:   nextState = sStrAddr;
                    default: nextState = fetch1;
                endcase
            end
            sAlu: begin
                ctrl.sr1Mux  = 1'b1;
                // ir[5] picks imm5 over sr2
                ctrl.sr2Mux  = ir[5];
                ctrl.gateAlu = 1'b1;
                ctrl.ldReg   = 1'b1;
                ctrl.ldCc    = 1'b1;
                if (opcode == opAnd)
                    ctrl.aluk = aluAnd;
                else if (opcode == opNot)
                    ctrl.aluk = aluNot;
                else
                    ctrl.aluk = aluAdd;
                nextState = fetch1;
            end
            // pc + offset9 only when the branch is taken
            sBr: begin
                ctrl.addr2Mux = 2'd2;
                ctrl.pcMux    = 2'd2;
                ctrl.ldPc     = ben;
                nextState     = fetch1;
            end
            sJmp: begin
                ctrl.sr1Mux   = 1'b1;
                ctrl.addr1Mux = 1'b1;
                ctrl.pcMux    = 2'd2;
                ctrl.ldPc     = 1'b1;
                nextState     = fetch1;
            end
            // r7 <- pc and pc <- target in the same cycle
            sJsr: begin
                ctrl.gatePc = 1'b1;
                ctrl.drMux  = 1'b1;
                ctrl.ldReg  = 1'b1;
                ctrl.sr1Mux = 1'b1;
                ctrl.pcMux  = 2'd2;
                ctrl.ldPc   = 1'b1;
                if (ir[11])
                    ctrl.addr2Mux = 2'd3;
                else
                    ctrl.addr1Mux = 1'b1;
                nextState = fetch1;
            end
            sLea: begin
                ctrl.addr2Mux   = 2'd2;
                ctrl.gateMarMux = 1'b1;
                ctrl.ldReg      = 1'b1;
                nextState       = fetch1;
            end
            sPause: begin
                ctrl.ldLed = 1'b1;
                nextState  = fetch1;
            end
            sLdAddr: begin
                ctrl.addr2Mux   = 2'd2;
                ctrl.gateMarMux = 1'b1;
                ctrl.ldMar      = 1'b1;
                nextState       = sLdRead;
            end
            sLdrAddr: begin
                ctrl.sr1Mux     = 1'b1;
                ctrl.addr1Mux   = 1'b1;
                ctrl.addr2Mux   = 2'd1;
                ctrl.gateMarMux = 1'b1;
                ctrl.ldMar      = 1'b1;
                nextState       = sLdRead;
            end
            sLdRead: begin
                memReq     = 1'b1;
                ctrl.mioEn = 1'b1;
                ctrl.ldMdr = memDone;
                if (memDone)
                    nextState = sLdLoad;
            end
            sLdLoad: begin
                ctrl.gateMdr = 1'b1;
                ctrl.ldReg   = 1'b1;
                ctrl.ldCc    = 1'b1;
                nextState    = fetch1;
            end
            sStAddr: begin
                ctrl.addr2Mux   = 2'd2;
                ctrl.gateMarMux = 1'b1;
                ctrl.ldMar      = 1'b1;
                nextState       = sStData;
            end
            sStrAddr: begin
                ctrl.sr1Mux     = 1'b1;
                ctrl.addr1Mux   = 1'b1;
                ctrl.addr2Mux   = 2'd1;
                ctrl.gateMarMux = 1'b1;
                ctrl.ldMar      = 1'b1;
                nextState       = sStData;
            end
            // source register ir[11:9] through the alu into mdr
            sStData: begin
                ctrl.aluk    = aluPassA;
                ctrl.gateAlu = 1'b1;
                ctrl.ldMdr   = 1'b1;
                nextState    = sStWrite;
            end
            sStWrite: begin
                memReq   = 1'b1;
                memWrite = 1'b1;
                if (memDone)
                    nextState = fetch1;
            end
            default: nextState = fetch1;
        endcase
    end

endmodule

/* datapath.sv */
`timescale 1ns/1ps

module datapath
    import lc3Pkg::*;
#(
    parameter logic [15:0] startAddr = 16'h3000
) (
    input  logic        Clk,
    input  logic        reset,
    input  ctrlSignals  ctrl,
    input  logic [15:0] memData,
    output logic [15:0] ir,
    output logic [15:0] mar,
    output logic [15:0] mdr,
    output logic [15:0] pc,
    output logic        ben,
    output logic [11:0] led
);

    logic [wordWidth-1:0] bus;
    logic [wordWidth-1:0] aluOut;
    logic [wordWidth-1:0] aluB;
    logic [wordWidth-1:0] addr1;
    logic [wordWidth-1:0] addr2;
    logic [wordWidth-1:0] addrSum;
    logic [wordWidth-1:0] pcNext;
    logic [wordWidth-1:0] sr1Out;
    logic [wordWidth-1:0] sr2Out;
    logic [wordWidth-1:0] sext5;
    logic [wordWidth-1:0] sext6;
    logic [wordWidth-1:0] sext9;
    logic [wordWidth-1:0] sext11;
    logic [2:0]           dr;
    logic [2:0]           sr1;
    logic [2:0]           nzp;
    logic [2:0]           nzpIn;

    // immediate and offset fields
    assign sext5  = {{11{ir[4]}}, ir[4:0]};
    assign sext6  = {{10{ir[5]}}, ir[5:0]};
    assign sext9  = {{7{ir[8]}}, ir[8:0]};
    assign sext11 = {{5{ir[10]}}, ir[10:0]};

    // r7 is the link register for jsr
    assign dr  = ctrl.drMux ? 3'd7 : ir[11:9];
    assign sr1 = ctrl.sr1Mux ? ir[8:6] : ir[11:9];

    regFile regs0 (
        .Clk    (Clk),
        .reset  (reset),
        .ld     (ctrl.ldReg),
        .dr     (dr),
        .sr1    (sr1),
        .sr2    (ir[2:0]),
        .din    (bus),
        .sr1Out (sr1Out),
        .sr2Out (sr2Out)
    );

    // address adder
    assign addr1 = ctrl.addr1Mux ? sr1Out : pc;

    always_comb begin
        case (ctrl.addr2Mux)
            2'd0:    addr2 = '0;
            2'd1:    addr2 = sext6;
            2'd2:    addr2 = sext9;
            default: addr2 = sext11;
        endcase
    end

    assign addrSum = addr1 + addr2;

    // alu
    assign aluB = ctrl.sr2Mux ? sext5 : sr2Out;

    always_comb begin
        case (ctrl.aluk)
            aluAdd:  aluOut = sr1Out + aluB;
            aluAnd:  aluOut = sr1Out & aluB;
            aluNot:  aluOut = ~sr1Out;
            default: aluOut = sr1Out;
        endcase
    end

    // one gate at a time drives the bus
    always_comb begin
        if (ctrl.gatePc) begin
            bus = pc;
        end else if (ctrl.gateMdr) begin
            bus = mdr;
        end else if (ctrl.gateAlu) begin
            bus = aluOut;
        end else if (ctrl.gateMarMux) begin
            bus = addrSum;
        end else begin
            bus = '0;
        end
    end

    // pc source is the increment, the bus or the adder
    always_comb begin
        case (ctrl.pcMux)
            2'd1:    pcNext = bus;
            2'd2:    pcNext = addrSum;
            default: pcNext = pc + 16'd1;
        endcase
    end

    assign nzpIn = {bus[15], bus == '0, !bus[15] && bus != '0};

    always_ff @(posedge Clk) begin
        if (reset) begin
            pc  <= startAddr;
            ir  <= '0;
            mar <= '0;
            mdr <= '0;
            nzp <= '0;
            ben <= 1'b0;
            led <= '0;
        end else begin
            if (ctrl.ldPc)
                pc <= pcNext;
            if (ctrl.ldIr)
                ir <= bus;
            if (ctrl.ldMar)
                mar <= bus;
            if (ctrl.ldMdr)
                mdr <= ctrl.mioEn ? memData : bus;
            if (ctrl.ldCc)
                nzp <= nzpIn;
            if (ctrl.ldBen)
                ben <= |(ir[11:9] & nzp);
            if (ctrl.ldLed)
                led <= ir[11:0];
        end
    end

endmodule

/* regFile.sv */
`timescale 1ns/1ps

module regFile
    import lc3Pkg::*;
(
    input  logic                 Clk,
    input  logic                 reset,
    input  logic                 ld,
    input  logic [2:0]           dr,
    input  logic [2:0]           sr1,
    input  logic [2:0]           sr2,
    input  logic [wordWidth-1:0] din,
    output logic [wordWidth-1:0] sr1Out,
    output logic [wordWidth-1:0] sr2Out
);

    // r0 .. r7
    logic [wordWidth-1:0] regs [8];

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (ld) begin
            regs[dr] <= din;
        end
    end

    // both read ports see the old value during a write
    assign sr1Out = regs[sr1];
    assign sr2Out = regs[sr2];

endmodule

/* lc3Pkg.sv */
package lc3Pkg;

    // data and address width of the core
    parameter int wordWidth = 16;

    // opcode field ir[15:12], only the implemented subset
    typedef enum logic [3:0] {
        opBr    = 4'b0000,
        opAdd   = 4'b0001,
        opLd    = 4'b0010,
        opSt    = 4'b0011,
        opJsr   = 4'b0100,
        opAnd   = 4'b0101,
        opLdr   = 4'b0110,
        opStr   = 4'b0111,
        opNot   = 4'b1001,
        opJmp   = 4'b1100,
        opPause = 4'b1101,
        opLea   = 4'b1110
    } lc3Opcode;

    typedef enum logic [1:0] {
        aluAdd   = 2'b00,
        aluAnd   = 2'b01,
        aluNot   = 2'b10,
        aluPassA = 2'b11
    } aluFunc;

    // one bundle from the control unit to the datapath
    typedef struct packed {
        logic       ldMar;
        logic       ldMdr;
        logic       ldIr;
        logic       ldBen;
        logic       ldCc;
        logic       ldReg;
        logic       ldPc;
        logic       ldLed;
        logic       gatePc;
        logic       gateMdr;
        logic       gateAlu;
        logic       gateMarMux;
        logic       drMux;
        logic       sr1Mux;
        logic       sr2Mux;
        logic       addr1Mux;
        logic       mioEn;
        logic [1:0] addr2Mux;
        logic [1:0] pcMux;
        aluFunc     aluk;
    } ctrlSignals;

    // wishbone classic master to slave
    typedef struct packed {
        logic                 cyc;
        logic                 stb;
        logic                 we;
        logic [wordWidth-1:0] adr;
        logic [wordWidth-1:0] dat;
    } wbReq;

    // wishbone classic slave to master
    typedef struct packed {
        logic                 ack;
        logic [wordWidth-1:0] dat;
    } wbRsp;

endpackage
